//--- src/rob_pkg.sv
package rob_pkg;

    localparam int rob_id_w   = 3;  // Covers the default depth of 8
    localparam int arf_id_w   = 5;
    localparam int reg_data_w = 32;
    localparam int addr_w     = 32;

    typedef logic [rob_id_w-1:0]   rob_id_t;
    typedef logic [arf_id_w-1:0]   arf_id_t;
    typedef logic [reg_data_w-1:0] reg_data_t;
    typedef logic [addr_w-1:0]     addr_t;

    // What dispatch hands over for each new instruction
    typedef struct packed {
        logic    dst_valid;
        arf_id_t dst_arf_id;
        addr_t   pc;
    } rob_dispatch_data_t;

    // One ROB slot
    typedef struct packed {
        logic      dst_valid;   // Instruction writes an architectural register
        arf_id_t   dst_arf_id;
        addr_t     pc_npc;      // Dispatch pc, replaced by the ALU next pc on branches
        logic      ld_mispred;
        logic      br_mispred;
        logic      reg_ready;   // Result may be forwarded and retired
        reg_data_t reg_data;
    } rob_entry_t;

    // Full-entry write request for one update port
    typedef struct packed {
        logic       valid;
        rob_id_t    rob_id;
        rob_entry_t entry;
    } rob_wr_t;

endpackage

//--- src/rob_entry_ram.sv
`timescale 1ns/1ps

module rob_entry_ram #(
    parameter int n_entries = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // Tail side
    input  logic                                  enq_valid,
    output logic                                  enq_ready,
    input  rob_pkg::rob_entry_t                   enq_entry,
    output rob_pkg::rob_id_t                      enq_id,
    // Head side
    input  logic                                  deq_en,
    output logic                                  deq_valid,
    output rob_pkg::rob_entry_t                   deq_entry,
    output rob_pkg::rob_id_t                      deq_id,
    // Update and read ports
    input  rob_pkg::rob_wr_t    [2:0]             wr,
    input  rob_pkg::rob_id_t    [1:0]             rd_id,
    output rob_pkg::rob_entry_t [1:0]             rd_entry,
    output rob_pkg::rob_entry_t [n_entries-1:0]   state,
    input  logic                                  flush
);
    import rob_pkg::*;

    localparam int idx_w = $clog2(n_entries);
    localparam int cnt_w = idx_w + 1;

    if (n_entries < 2 || n_entries > (1 << rob_id_w) ||
        (n_entries & (n_entries - 1)) != 0) begin : g_bad_depth
        $error("rob_entry_ram: n_entries must be a power of two from 2 to %0d",
               1 << rob_id_w);
    end

    rob_entry_t [n_entries-1:0] entries;
    rob_id_t                    head;
    rob_id_t                    tail;
    logic [cnt_w-1:0]           count;
    logic                       enq_fire;

    function automatic rob_id_t next_ptr(rob_id_t ptr);
        return (ptr == rob_id_t'(n_entries - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Slot lies between head and tail
    function automatic logic is_alloc(rob_id_t id);
        logic [idx_w-1:0] off;
        off = idx_w'(id - head);
        return (int'(id) < n_entries) && (cnt_w'(off) < count);
    endfunction

    function automatic logic wr_hit(int a, int b);
        return wr[a].valid && wr[b].valid && (wr[a].rob_id == wr[b].rob_id);
    endfunction

    assign enq_ready = (count != cnt_w'(n_entries));
    assign enq_fire  = enq_valid & enq_ready;
    assign enq_id    = tail;

    assign deq_valid = (count != '0);
    assign deq_entry = entries[head];
    assign deq_id    = head;

    assign rd_entry[0] = entries[rd_id[0]];
    assign rd_entry[1] = entries[rd_id[1]];
    assign state       = entries;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entries <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else if (flush) begin
            // Redirect drops everything in flight, including a same-cycle enqueue
            entries <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else begin
            if (enq_fire) begin
                entries[tail] <= enq_entry;
                tail          <= next_ptr(tail);
            end
            // Later ports override earlier ones on the same slot
            for (int p = 0; p < 3; p++) begin
                if (wr[p].valid) begin
                    entries[wr[p].rob_id] <= wr[p].entry;
                end
            end
            if (deq_en) begin
                head <= next_ptr(head);
            end
            count <= count + cnt_w'(enq_fire) - cnt_w'(deq_en);
        end
    end

    for (genvar p = 0; p < 3; p++) begin : g_wr_chk
        a_wr_allocated: assert property (@(posedge clk) disable iff (!rst_n)
            wr[p].valid && !flush |-> is_alloc(wr[p].rob_id))
            else $error("rob_entry_ram: write port %0d hits free slot %0d", p, wr[p].rob_id);
    end

    a_wr_collision: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_hit(0, 1) || wr_hit(0, 2) || wr_hit(1, 2)))
        else $error("rob_entry_ram: two write ports target one slot");

    a_deq_empty: assert property (@(posedge clk) disable iff (!rst_n)
        deq_en |-> deq_valid)
        else $error("rob_entry_ram: dequeue while empty");

endmodule

//--- src/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int n_entries = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Dispatch with a ready-then-valid handshake
    input  logic                        dispatch_valid,
    output logic                        dispatch_ready,
    output rob_pkg::rob_id_t            dispatch_rob_id,
    input  rob_pkg::rob_dispatch_data_t dispatch_data,
    // Retire into the ARF
    output logic                        retire,
    output rob_pkg::rob_id_t            retire_rob_id,
    output logic                        retire_dst_valid,
    output rob_pkg::arf_id_t            retire_arf_id,
    output rob_pkg::reg_data_t          retire_reg_data,
    output logic                        retire_redirect_pc_valid,
    output rob_pkg::addr_t              retire_redirect_pc,
    // Operand reads
    input  rob_pkg::rob_id_t            rob_id_src1,
    output logic                        rob_reg_ready_src1,
    output rob_pkg::reg_data_t          rob_reg_data_src1,
    input  rob_pkg::rob_id_t            rob_id_src2,
    output logic                        rob_reg_ready_src2,
    output rob_pkg::reg_data_t          rob_reg_data_src2,
    // Integer wakeup
    input  logic                        iiq_wakeup_valid,
    input  rob_pkg::rob_id_t            iiq_wakeup_rob_id,
    // ALU writeback
    input  logic                        alu_wb_valid,
    input  rob_pkg::rob_id_t            alu_wb_rob_id,
    input  rob_pkg::reg_data_t          alu_wb_reg_data,
    input  logic                        alu_npc_wb_valid,
    input  logic                        alu_npc_mispred,
    input  rob_pkg::addr_t              alu_npc,
    // Load writeback
    input  logic                        ld_wb_valid,
    input  rob_pkg::rob_id_t            ld_wb_rob_id,
    input  rob_pkg::reg_data_t          ld_wb_reg_data,
    input  logic                        ld_wb_ld_mispred,
    // Flush
    input  logic                        fetch_redirect_valid
);
    import rob_pkg::*;

    rob_entry_t                 dispatch_entry;
    rob_entry_t                 head_entry;
    rob_entry_t [1:0]           rd_entry;
    rob_entry_t [n_entries-1:0] state;
    rob_wr_t    [2:0]           wr;
    logic                       head_valid;
    logic                       head_done;
    logic                       head_mispred;

    // New slot starts not ready with no mispredict
    always_comb begin
        dispatch_entry            = '0;
        dispatch_entry.dst_valid  = dispatch_data.dst_valid;
        dispatch_entry.dst_arf_id = dispatch_data.dst_arf_id;
        dispatch_entry.pc_npc     = dispatch_data.pc;
    end

    // Each update rewrites the whole slot merged over what is stored
    always_comb begin
        wr[0].valid           = iiq_wakeup_valid;
        wr[0].rob_id          = iiq_wakeup_rob_id;
        wr[0].entry           = state[iiq_wakeup_rob_id];
        wr[0].entry.reg_ready = 1'b1;

        wr[1].valid           = alu_wb_valid;
        wr[1].rob_id          = alu_wb_rob_id;
        wr[1].entry           = state[alu_wb_rob_id];
        wr[1].entry.reg_data  = alu_wb_reg_data;
        wr[1].entry.reg_ready = 1'b1;
        if (alu_npc_wb_valid) begin  // Branch resolved
            wr[1].entry.pc_npc     = alu_npc;
            wr[1].entry.br_mispred = alu_npc_mispred;
        end

        wr[2].valid            = ld_wb_valid;
        wr[2].rob_id           = ld_wb_rob_id;
        wr[2].entry            = state[ld_wb_rob_id];
        wr[2].entry.reg_data   = ld_wb_reg_data;
        wr[2].entry.ld_mispred = ld_wb_ld_mispred;
        wr[2].entry.reg_ready  = 1'b1;
    end

    rob_entry_ram #(
        .n_entries (n_entries)
    ) u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq_valid (dispatch_valid),
        .enq_ready (dispatch_ready),
        .enq_entry (dispatch_entry),
        .enq_id    (dispatch_rob_id),
        .deq_en    (retire),
        .deq_valid (head_valid),
        .deq_entry (head_entry),
        .deq_id    (retire_rob_id),
        .wr        (wr),
        .rd_id     ({rob_id_src2, rob_id_src1}),
        .rd_entry  (rd_entry),
        .state     (state),
        .flush     (fetch_redirect_valid)
    );

    assign rob_reg_ready_src1 = rd_entry[0].reg_ready;
    assign rob_reg_data_src1  = rd_entry[0].reg_data;
    assign rob_reg_ready_src2 = rd_entry[1].reg_ready;
    assign rob_reg_data_src2  = rd_entry[1].reg_data;

    assign head_done    = head_valid & head_entry.reg_ready;
    assign head_mispred = head_entry.br_mispred | head_entry.ld_mispred;

    // A mispredicted head blocks here until fetch flushes us
    assign retire                   = head_done & ~head_mispred;
    assign retire_redirect_pc_valid = head_done & head_mispred;
    assign retire_redirect_pc       = head_entry.pc_npc;
    assign retire_dst_valid         = head_entry.dst_valid;
    assign retire_arf_id            = head_entry.dst_arf_id;
    assign retire_reg_data          = head_entry.reg_data;

    // Redirect holds until fetch answers it with a flush
    a_redirect_held: assert property (@(posedge clk) disable iff (!rst_n)
        retire_redirect_pc_valid && !fetch_redirect_valid |=> retire_redirect_pc_valid)
        else $error("rob: redirect dropped before the fetch flush");

endmodule

//--- src/arf.sv
`timescale 1ns/1ps

module arf #(
    parameter int n_arf_regs = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  rob_pkg::arf_id_t   wr_id,
    input  rob_pkg::reg_data_t wr_data,
    input  rob_pkg::arf_id_t   rd_id,
    output rob_pkg::reg_data_t rd_data
);
    import rob_pkg::*;

    if (n_arf_regs < 2 || n_arf_regs > (1 << arf_id_w)) begin : g_bad_size
        $error("arf: n_arf_regs must be from 2 to %0d", 1 << arf_id_w);
    end

    reg_data_t [n_arf_regs-1:0] regs;
    logic                       wr_ok;

    // x0 is hardwired, ids past the end are ignored
    assign wr_ok = wr_en && (wr_id != '0) && (int'(wr_id) < n_arf_regs);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wr_ok) begin
            regs[wr_id] <= wr_data;
        end
    end

    always_comb begin
        if (rd_id == '0 || int'(rd_id) >= n_arf_regs) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_id];
        end
    end

endmodule

//--- src/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
    parameter int n_entries  = 8,
    parameter int n_arf_regs = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dispatch_valid,
    output logic                        dispatch_ready,
    output rob_pkg::rob_id_t            dispatch_rob_id,
    input  rob_pkg::rob_dispatch_data_t dispatch_data,
    output logic                        retire,
    output rob_pkg::rob_id_t            retire_rob_id,
    output logic                        retire_dst_valid,
    output rob_pkg::arf_id_t            retire_arf_id,
    output rob_pkg::reg_data_t          retire_reg_data,
    output logic                        retire_redirect_pc_valid,
    output rob_pkg::addr_t              retire_redirect_pc,
    input  rob_pkg::rob_id_t            rob_id_src1,
    output logic                        rob_reg_ready_src1,
    output rob_pkg::reg_data_t          rob_reg_data_src1,
    input  rob_pkg::rob_id_t            rob_id_src2,
    output logic                        rob_reg_ready_src2,
    output rob_pkg::reg_data_t          rob_reg_data_src2,
    input  logic                        iiq_wakeup_valid,
    input  rob_pkg::rob_id_t            iiq_wakeup_rob_id,
    input  logic                        alu_wb_valid,
    input  rob_pkg::rob_id_t            alu_wb_rob_id,
    input  rob_pkg::reg_data_t          alu_wb_reg_data,
    input  logic                        alu_npc_wb_valid,
    input  logic                        alu_npc_mispred,
    input  rob_pkg::addr_t              alu_npc,
    input  logic                        ld_wb_valid,
    input  rob_pkg::rob_id_t            ld_wb_rob_id,
    input  rob_pkg::reg_data_t          ld_wb_reg_data,
    input  logic                        ld_wb_ld_mispred,
    input  logic                        fetch_redirect_valid,
    // Debug read of architectural state
    input  rob_pkg::arf_id_t            arf_rd_id,
    output rob_pkg::reg_data_t          arf_rd_data
);

    rob #(
        .n_entries (n_entries)
    ) u_rob (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .dispatch_valid           (dispatch_valid),
        .dispatch_ready           (dispatch_ready),
        .dispatch_rob_id          (dispatch_rob_id),
        .dispatch_data            (dispatch_data),
        .retire                   (retire),
        .retire_rob_id            (retire_rob_id),
        .retire_dst_valid         (retire_dst_valid),
        .retire_arf_id            (retire_arf_id),
        .retire_reg_data          (retire_reg_data),
        .retire_redirect_pc_valid (retire_redirect_pc_valid),
        .retire_redirect_pc       (retire_redirect_pc),
        .rob_id_src1              (rob_id_src1),
        .rob_reg_ready_src1       (rob_reg_ready_src1),
        .rob_reg_data_src1        (rob_reg_data_src1),
        .rob_id_src2              (rob_id_src2),
        .rob_reg_ready_src2       (rob_reg_ready_src2),
        .rob_reg_data_src2        (rob_reg_data_src2),
        .iiq_wakeup_valid         (iiq_wakeup_valid),
        .iiq_wakeup_rob_id        (iiq_wakeup_rob_id),
        .alu_wb_valid             (alu_wb_valid),
        .alu_wb_rob_id            (alu_wb_rob_id),
        .alu_wb_reg_data          (alu_wb_reg_data),
        .alu_npc_wb_valid         (alu_npc_wb_valid),
        .alu_npc_mispred          (alu_npc_mispred),
        .alu_npc                  (alu_npc),
        .ld_wb_valid              (ld_wb_valid),
        .ld_wb_rob_id             (ld_wb_rob_id),
        .ld_wb_reg_data           (ld_wb_reg_data),
        .ld_wb_ld_mispred         (ld_wb_ld_mispred),
        .fetch_redirect_valid     (fetch_redirect_valid)
    );

    // ARF never stalls retirement
    arf #(
        .n_arf_regs (n_arf_regs)
    ) u_arf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (retire & retire_dst_valid),
        .wr_id   (retire_arf_id),
        .wr_data (retire_reg_data),
        .rd_id   (arf_rd_id),
        .rd_data (arf_rd_data)
    );

endmodule

//--- verif/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam int n_entries  = 8;
    localparam int n_arf_regs = 32;
    localparam int wait_limit = 200;  // Cycles allowed for any single wait

    // What the model remembers of one in-flight instruction
    typedef struct packed {
        logic      dst_valid;
        arf_id_t   dst;
        addr_t     pc;
        logic      ready;
        reg_data_t data;
        logic      npc_valid;
        logic      br_mis;
        addr_t     npc;
        logic      ld_mis;
    } model_entry_t;

    typedef struct packed {
        logic  redirect;  // Entry stalls at the head and redirects fetch
        addr_t value;     // Retired data or the redirect pc
    } outcome_t;

    logic               clk;
    logic               rst_n;
    logic               dispatch_valid;
    logic               dispatch_ready;
    rob_id_t            dispatch_rob_id;
    rob_dispatch_data_t dispatch_data;
    logic               retire;
    rob_id_t            retire_rob_id;
    logic               retire_dst_valid;
    arf_id_t            retire_arf_id;
    reg_data_t          retire_reg_data;
    logic               retire_redirect_pc_valid;
    addr_t              retire_redirect_pc;
    rob_id_t            rob_id_src1;
    logic               rob_reg_ready_src1;
    reg_data_t          rob_reg_data_src1;
    rob_id_t            rob_id_src2;
    logic               rob_reg_ready_src2;
    reg_data_t          rob_reg_data_src2;
    logic               iiq_wakeup_valid;
    rob_id_t            iiq_wakeup_rob_id;
    logic               alu_wb_valid;
    rob_id_t            alu_wb_rob_id;
    reg_data_t          alu_wb_reg_data;
    logic               alu_npc_wb_valid;
    logic               alu_npc_mispred;
    addr_t              alu_npc;
    logic               ld_wb_valid;
    rob_id_t            ld_wb_rob_id;
    reg_data_t          ld_wb_reg_data;
    logic               ld_wb_ld_mispred;
    logic               fetch_redirect_valid;
    arf_id_t            arf_rd_id;
    reg_data_t          arf_rd_data;

    model_entry_t model_mem [n_entries];
    rob_id_t      order_q [$];           // Program order of live entries
    reg_data_t    arf_model [n_arf_regs];
    integer       seed = 32'h02f3_065b;
    int           value_errors = 0;
    int           other_errors = 0;

    rob_top #(
        .n_entries  (n_entries),
        .n_arf_regs (n_arf_regs)
    ) UUT (.*);

    always #20 clk = ~clk;

    function automatic outcome_t expected_outcome(model_entry_t e);
        outcome_t o;
        o.redirect = e.ld_mis || (e.npc_valid && e.br_mis);
        if (o.redirect) begin
            o.value = e.npc_valid ? e.npc : e.pc;  // Resolved npc replaces the dispatch pc
        end else begin
            o.value = e.data;
        end
        return o;
    endfunction

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("Timeout while waiting for %s", what);
        other_errors++;
        finish_run();
    endtask

    // Retire pulses are compared against the oldest model entry
    always @(negedge clk) begin : retire_monitor
        outcome_t exp_out;
        rob_id_t  id;
        if (rst_n && retire) begin
            if (order_q.size() == 0) begin
                $display("Retire raised while no entry was expected in the ROB");
                other_errors++;
            end else begin
                id      = order_q.pop_front();
                exp_out = expected_outcome(model_mem[id]);
                if (!model_mem[id].ready) begin
                    $display("Entry %0d retired before it was marked ready", id);
                    other_errors++;
                end
                if (exp_out.redirect) begin
                    $display("Entry %0d retired although it carries a mispredict", id);
                    other_errors++;
                end
                check_value("retire_rob_id", id, retire_rob_id);
                check_value("retire_dst_valid", model_mem[id].dst_valid, retire_dst_valid);
                check_value("retire_reg_data", exp_out.value, retire_reg_data);
                if (model_mem[id].dst_valid) begin
                    check_value("retire_arf_id", model_mem[id].dst, retire_arf_id);
                    if (model_mem[id].dst != '0) begin
                        arf_model[model_mem[id].dst] = exp_out.value;
                    end
                end
            end
        end
    end

    task automatic drive_dispatch(logic dst_valid, arf_id_t dst, addr_t pc, output rob_id_t id);
        int n;
        dispatch_valid           = 1'b1;
        dispatch_data.dst_valid  = dst_valid;
        dispatch_data.dst_arf_id = dst;
        dispatch_data.pc         = pc;
        n = 0;
        @(negedge clk);
        while (!dispatch_ready) begin
            n++;
            if (n == wait_limit) report_timeout("dispatch_ready");
            @(negedge clk);
        end
        id                      = dispatch_rob_id;
        model_mem[id]           = '0;
        model_mem[id].dst_valid = dst_valid;
        model_mem[id].dst       = dst;
        model_mem[id].pc        = pc;
        order_q.push_back(id);
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;
    endtask

    task automatic dispatch_random(output rob_id_t id);
        logic    dst_valid;
        arf_id_t dst;
        addr_t   pc;
        dst_valid = ($random(seed) & 3) != 0;  // About one in four has no destination
        dst       = $random(seed);
        pc        = $random(seed) & ~32'h3;
        drive_dispatch(dst_valid, dst, pc, id);
    endtask

    task automatic alu_writeback(rob_id_t id, reg_data_t data, logic npc_valid, logic mispred,
                                 addr_t npc);
        alu_wb_valid     = 1'b1;
        alu_wb_rob_id    = id;
        alu_wb_reg_data  = data;
        alu_npc_wb_valid = npc_valid;
        alu_npc_mispred  = mispred;
        alu_npc          = npc;
        model_mem[id].ready = 1'b1;
        model_mem[id].data  = data;
        if (npc_valid) begin
            model_mem[id].npc_valid = 1'b1;
            model_mem[id].br_mis    = mispred;
            model_mem[id].npc       = npc;
        end
        @(posedge clk);
        #2;
        alu_wb_valid     = 1'b0;
        alu_npc_wb_valid = 1'b0;
        alu_npc_mispred  = 1'b0;
    endtask

    task automatic load_writeback(rob_id_t id, reg_data_t data, logic mispred);
        ld_wb_valid      = 1'b1;
        ld_wb_rob_id     = id;
        ld_wb_reg_data   = data;
        ld_wb_ld_mispred = mispred;
        model_mem[id].ready  = 1'b1;
        model_mem[id].data   = data;
        model_mem[id].ld_mis = mispred;
        @(posedge clk);
        #2;
        ld_wb_valid      = 1'b0;
        ld_wb_ld_mispred = 1'b0;
    endtask

    task automatic wakeup_entry(rob_id_t id);
        iiq_wakeup_valid    = 1'b1;
        iiq_wakeup_rob_id   = id;
        model_mem[id].ready = 1'b1;
        @(posedge clk);
        #2;
        iiq_wakeup_valid = 1'b0;
    endtask

    task automatic redirect_fetch();
        fetch_redirect_valid = 1'b1;
        @(posedge clk);
        #2;
        fetch_redirect_valid = 1'b0;
        order_q.delete();  // Flush drops every entry in flight
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (order_q.size() != 0) begin
            n++;
            if (n == wait_limit) report_timeout("every ROB entry to retire");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic compare_arf();
        for (int r = 0; r < n_arf_regs; r++) begin
            arf_rd_id = arf_id_t'(r);
            @(negedge clk);
            check_value($sformatf("arf x%0d", r), arf_model[r], arf_rd_data);
            @(posedge clk);
            #2;
        end
    endtask

    // Branch or load mispredict on the head followed by a fetch flush
    task automatic mispredict_case(logic is_load);
        rob_id_t  ids [3];
        rob_id_t  id;
        outcome_t exp_out;
        int       n;
        for (int i = 0; i < 3; i++) begin
            dispatch_random(ids[i]);
        end
        alu_writeback(ids[2], $random(seed), 1'b0, 1'b0, '0);
        if (is_load) begin
            load_writeback(ids[1], $random(seed), 1'b1);
        end else begin
            alu_writeback(ids[1], $random(seed), 1'b1, 1'b1, $random(seed) & ~32'h3);
        end
        alu_writeback(ids[0], $random(seed), 1'b0, 1'b0, '0);
        exp_out = expected_outcome(model_mem[ids[1]]);
        n = 0;
        @(negedge clk);
        while (!retire_redirect_pc_valid) begin
            n++;
            if (n == wait_limit) report_timeout("retire_redirect_pc_valid");
            @(negedge clk);
        end
        check_value("retire_redirect_pc", exp_out.value, retire_redirect_pc);
        repeat (3) begin  // Head stays blocked until the flush
            @(negedge clk);
            check_value("redirect held", 1'b1, retire_redirect_pc_valid);
            check_value("retire blocked", 1'b0, retire);
        end
        @(posedge clk);
        #2;
        rob_id_src1 = ids[2];  // Already written, so ready until the flush
        redirect_fetch();
        @(negedge clk);
        check_value("entry ready after flush", 1'b0, rob_reg_ready_src1);
        check_value("redirect after flush", 1'b0, retire_redirect_pc_valid);
        check_value("dispatch_rob_id after flush", 0, dispatch_rob_id);
        @(posedge clk);
        #2;
        dispatch_random(id);
        check_value("first id after flush", 0, id);
        alu_writeback(id, $random(seed), 1'b0, 1'b0, '0);
        wait_drained();
        compare_arf();
    endtask

    initial begin
        rob_id_t   id;
        rob_id_t   ids [n_entries];
        rob_id_t   tmp;
        reg_data_t data;
        int        j;
        clk                  = 1'b0;
        rst_n                = 1'b0;
        dispatch_valid       = 1'b0;
        dispatch_data        = '0;
        rob_id_src1          = '0;
        rob_id_src2          = '0;
        iiq_wakeup_valid     = 1'b0;
        iiq_wakeup_rob_id    = '0;
        alu_wb_valid         = 1'b0;
        alu_wb_rob_id        = '0;
        alu_wb_reg_data      = '0;
        alu_npc_wb_valid     = 1'b0;
        alu_npc_mispred      = 1'b0;
        alu_npc              = '0;
        ld_wb_valid          = 1'b0;
        ld_wb_rob_id         = '0;
        ld_wb_reg_data       = '0;
        ld_wb_ld_mispred     = 1'b0;
        fetch_redirect_valid = 1'b0;
        arf_rd_id            = '0;
        for (int r = 0; r < n_arf_regs; r++) arf_model[r] = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("retire after reset", 1'b0, retire);
        check_value("redirect after reset", 1'b0, retire_redirect_pc_valid);
        check_value("dispatch_rob_id after reset", 0, dispatch_rob_id);
        check_value("dispatch_ready after reset", 1'b1, dispatch_ready);
        @(posedge clk);
        #2;

        // Allocation in id order until full
        for (int i = 0; i < n_entries; i++) begin
            dispatch_random(id);
            check_value("dispatch id", i, id);
        end
        dispatch_valid           = 1'b1;  // Held dispatch that writes x0
        dispatch_data.dst_valid  = 1'b1;
        dispatch_data.dst_arf_id = '0;
        dispatch_data.pc         = 32'h0000_0400;
        repeat (3) begin
            @(negedge clk);
            check_value("dispatch_ready when full", 1'b0, dispatch_ready);
        end
        @(posedge clk);
        #2;
        alu_writeback(0, $random(seed), 1'b0, 1'b0, '0);
        drive_dispatch(1'b1, '0, 32'h0000_0400, id);
        check_value("held dispatch id", 0, id);

        // Out-of-order completion with in-order retirement
        for (int round = 0; round < 3; round++) begin
            if (round > 0) begin
                for (int i = 0; i < n_entries; i++) dispatch_random(id);
            end
            for (int i = 0; i < n_entries; i++) ids[i] = order_q[i];
            for (int i = n_entries - 1; i > 0; i--) begin
                j      = $unsigned($random(seed)) % (i + 1);
                tmp    = ids[i];
                ids[i] = ids[j];
                ids[j] = tmp;
            end
            for (int i = 0; i < n_entries; i++) begin
                if ($random(seed) & 1) begin
                    load_writeback(ids[i], $random(seed), 1'b0);
                end else begin
                    alu_writeback(ids[i], $random(seed), 1'($random(seed)), 1'b0,
                                  $random(seed));
                end
            end
            wait_drained();
        end
        compare_arf();

        // Operand reads where the second entry is younger than the head
        dispatch_random(ids[0]);
        dispatch_random(ids[1]);
        rob_id_src1 = ids[1];
        rob_id_src2 = ids[0];
        @(negedge clk);
        check_value("src1 ready before wakeup", 1'b0, rob_reg_ready_src1);
        check_value("src2 ready before writeback", 1'b0, rob_reg_ready_src2);
        @(posedge clk);
        #2;
        wakeup_entry(ids[1]);
        @(negedge clk);
        check_value("src1 ready after wakeup", 1'b1, rob_reg_ready_src1);
        @(posedge clk);
        #2;
        data = $random(seed);
        alu_writeback(ids[1], data, 1'b0, 1'b0, '0);
        @(negedge clk);
        check_value("src1 data after writeback", data, rob_reg_data_src1);
        @(posedge clk);
        #2;
        data = $random(seed);
        load_writeback(ids[0], data, 1'b0);
        @(negedge clk);
        check_value("src2 ready after load", 1'b1, rob_reg_ready_src2);
        check_value("src2 data after load", data, rob_reg_data_src2);
        @(posedge clk);
        #2;
        wait_drained();

        mispredict_case(1'b0);
        mispredict_case(1'b1);
        finish_run();
    end

endmodule

//--- tb.f
src/rob_pkg.sv
src/rob_entry_ram.sv
src/rob.sv
src/arf.sv
src/rob_top.sv
verif/rob_tb.sv

//--- Bender.yml
package:
  name: rob

sources:
  - src/rob_pkg.sv
  - src/rob_entry_ram.sv
  - src/rob.sv
  - src/arf.sv
  - src/rob_top.sv
  - target: test
    files:
      - verif/rob_tb.sv
